/* include/calc_macros.svh */
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// stable press cycles before a key is taken
`define DEBOUNCE_CYCLES 10

// seven-segment digits on the board
`define NUM_DIGITS 4

// clocks each digit stays lit
`define REFRESH_DIV 8

// calculator word, wraps modulo 2**DATA_W
`define DATA_W 16

`endif

/* source/calc_key_pkg.sv */
`default_nettype none

package calc_key_pkg;

    // operator codes as sent by the keypad scanner
    typedef enum logic [2:0] {
        op_none = 3'd0,                     // digit, equal or ignored key
        op_neg  = 3'd1,                     // change sign of entry
        op_add  = 3'd2,
        op_sub  = 3'd3,
        op_mul  = 3'd4
    } op_e;

    // matrix position of a pressed key
    typedef struct packed {
        logic [1:0] row;                    // upper bits of index
        logic [1:0] col;                    // lower bits of index
    } key_pos_s;

    // one key, seen as a position at capture and as an index for decode
    typedef union packed {
        logic [3:0] raw;                    // row*4 + col
        key_pos_s   pos;
    } key_code_u;

    localparam logic [3:0] KEY_NONE = 4'hF; // digit value for non-digit keys

endpackage

`default_nettype wire

/* source/calc_disp_pkg.sv */
`default_nettype none

package calc_disp_pkg;

    // segments a..g in bits 0..6, low = lit
    typedef logic [6:0] seg_t;

    // one hex digit of the displayed word
    typedef logic [3:0] nibble_t;

    localparam seg_t SEG_OFF = 7'h7F;       // every segment dark

endpackage

`default_nettype wire

/* source/key_if.sv */
`timescale 1ns/1ps
`default_nettype none

// decoded key from keypad scanner to calculator controller
interface key_if import calc_key_pkg::*; ();

    logic       key_rdy;                    // key waiting, held until release
    logic       key_rd;                     // one-cycle read strobe
    logic [3:0] digit;                      // 0..9, F if not a digit
    op_e        op;                         // op_none unless operator key
    logic       equal;                      // '*' key

    modport scanner (
        output key_rdy, digit, op, equal,
        input  key_rd
    );

    modport controller (
        input  key_rdy, digit, op, equal,
        output key_rd
    );

endinterface

`default_nettype wire

/* source/input_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_macros.svh"

module input_control import calc_key_pkg::*; (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,              // pulled up, low = pressed
    output logic [3:0] col_out,             // one column driven low
    key_if.scanner     key
);

    localparam int CNT_W = $clog2(`DEBOUNCE_CYCLES + 1);

    typedef enum logic [2:0] {
        st_idle, st_scan, st_wait_stable, st_confirm, st_wait_release
    } state_e;

    state_e           state, next_state;
    logic [1:0]       col_idx;              // column driven now
    logic [1:0]       col_prev;             // column that row_in reflects
    logic [CNT_W-1:0] deb_cnt;              // stable low samples so far
    logic             key_valid;            // some row low
    logic [1:0]       row_sel;              // lowest low row
    logic             aligned;              // rows belong to driven column
    logic             rdy;
    key_code_u        key_code;             // captured press
    logic [3:0]       dec_digit;
    op_e              dec_op;
    logic             dec_equal;

    // rows come back one clock after the column drive
    assign aligned = (col_prev == col_idx);

    always_comb begin
        key_valid = ~&row_in;
        row_sel   = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_in[r])
                row_sel = 2'(r);            // lowest row wins
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle:         next_state = st_scan;
            st_scan:         next_state = key_valid ? st_wait_stable : st_scan;
            st_wait_stable: begin
                if (aligned && !key_valid)
                    next_state = st_scan;   // bounce restarts the scan
                else if (aligned && deb_cnt == CNT_W'(`DEBOUNCE_CYCLES - 1))
                    next_state = st_confirm;
            end
            st_confirm:      next_state = key.key_rd ? st_wait_release : st_confirm;
            st_wait_release: next_state = (aligned && !key_valid) ? st_idle : st_wait_release;
            default:         next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= st_idle;
            col_idx  <= 2'd0;
            col_prev <= 2'd0;
            deb_cnt  <= '0;
            rdy      <= 1'b0;
        end else begin
            state    <= next_state;
            col_prev <= col_idx;
            case (state)
                st_idle: col_idx <= col_idx + 2'd1;
                st_scan: begin
                    deb_cnt <= '0;
                    if (key_valid)
                        col_idx <= col_prev; // back to the column that hit
                    else
                        col_idx <= col_idx + 2'd1;
                end
                st_wait_stable: begin
                    if (aligned)
                        deb_cnt <= key_valid ? deb_cnt + CNT_W'(1) : '0;
                    if (next_state == st_confirm)
                        rdy <= 1'b1;
                end
                st_wait_release: begin
                    if (next_state == st_idle)
                        rdy <= 1'b0;        // only once rows are all high
                end
                default: ;
            endcase
        end
    end

    // key position taken on entering confirm
    always_ff @(posedge clk) begin
        if (state == st_wait_stable && next_state == st_confirm) begin
            key_code.pos.row <= row_sel;
            key_code.pos.col <= col_idx;
        end
    end

    // index to key meaning
    always_comb begin
        dec_digit = KEY_NONE;
        dec_op    = op_none;
        dec_equal = 1'b0;
        case (key_code.raw)
            4'h0: dec_digit = 4'd1;
            4'h1: dec_digit = 4'd2;
            4'h2: dec_digit = 4'd3;
            4'h3: dec_op    = op_add;
            4'h4: dec_digit = 4'd4;
            4'h5: dec_digit = 4'd5;
            4'h6: dec_digit = 4'd6;
            4'h7: dec_op    = op_sub;
            4'h8: dec_digit = 4'd7;
            4'h9: dec_digit = 4'd8;
            4'hA: dec_digit = 4'd9;
            4'hB: dec_op    = op_mul;
            4'hC: dec_equal = 1'b1;         // '*'
            4'hD: dec_digit = 4'd0;
            4'hE: ;                         // '#' ignored
            4'hF: dec_op    = op_neg;
            default: ;
        endcase
    end

    always_comb begin
        col_out          = 4'b1111;
        col_out[col_idx] = 1'b0;
    end

    assign key.key_rdy = rdy;
    assign key.digit   = dec_digit;
    assign key.op      = dec_op;
    assign key.equal   = dec_equal;

endmodule

`default_nettype wire

/* source/calc_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_macros.svh"

module calc_controller import calc_key_pkg::*, calc_disp_pkg::*; (
    input  logic                         clk,
    input  logic                         nRST,
    key_if.controller                    key,
    output nibble_t [`NUM_DIGITS-1:0]    digits, // displayed word, digit 0 lowest
    output logic    [`NUM_DIGITS-1:0]    blank   // leading zero digits off
);

    typedef logic [`DATA_W-1:0] word_t;

    word_t entry;                           // number being typed
    word_t acc;                             // running result
    word_t fold_val;                        // acc <pend> entry
    word_t disp_val;
    op_e   pend;                            // operator waiting for its operand
    logic  show_acc;                        // display acc instead of entry
    logic  rdy_q;                           // key_rdy last cycle
    logic  rd_q;
    logic  take;                            // new key this cycle

    assign take       = key.key_rdy & ~rdy_q; // rising edge only
    assign key.key_rd = rd_q;

    // all results wrap at word width
    always_comb begin
        case (pend)
            op_add:  fold_val = acc + entry;
            op_sub:  fold_val = acc - entry;
            op_mul:  fold_val = acc * entry;
            default: fold_val = entry;      // nothing pending, take entry
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            rdy_q    <= 1'b0;
            rd_q     <= 1'b0;
            entry    <= '0;
            acc      <= '0;
            pend     <= op_none;
            show_acc <= 1'b0;
        end else begin
            rdy_q <= key.key_rdy;
            rd_q  <= take;                  // strobe goes out as we act
            if (take) begin
                if (key.equal) begin
                    entry    <= fold_val;
                    pend     <= op_none;
                    show_acc <= 1'b0;
                end else if (key.op == op_neg) begin
                    entry    <= word_t'(0) - entry;
                    show_acc <= 1'b0;
                end else if (key.op != op_none) begin
                    acc      <= fold_val;
                    pend     <= key.op;
                    entry    <= '0;
                    show_acc <= 1'b1;
                end else if (key.digit != KEY_NONE) begin
                    entry    <= entry * word_t'(10) + word_t'(key.digit);
                    show_acc <= 1'b0;
                end
                // '#' arrives as no digit, no op, no equal: dropped
            end
        end
    end

    assign disp_val = show_acc ? acc : entry;

    always_comb begin
        for (int i = 0; i < `NUM_DIGITS; i++)
            digits[i] = disp_val[4*i +: 4];
    end

    // blank from the top down while digits stay zero, never digit 0
    always_comb begin
        logic zero_run;
        zero_run = 1'b1;
        blank    = '0;
        for (int i = `NUM_DIGITS - 1; i > 0; i--) begin
            zero_run = zero_run & (digits[i] == 4'h0);
            blank[i] = zero_run;
        end
    end

endmodule

`default_nettype wire

/* source/seg_digit.sv */
`timescale 1ns/1ps
`default_nettype none

module seg_digit import calc_disp_pkg::*; (
    input  nibble_t nib,
    input  logic    blank,                  // force dark
    output seg_t    seg                     // active low
);

    logic [6:0] lit;                        // gfedcba, high = on

    always_comb begin
        case (nib)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;              // lower case b
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;              // lower case d
            4'hE: lit = 7'h79;
            default: lit = 7'h71;           // F
        endcase
    end

    assign seg = blank ? SEG_OFF : seg_t'(~lit);

endmodule

`default_nettype wire

/* source/display_scan.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_macros.svh"

module display_scan import calc_disp_pkg::*; (
    input  logic                      clk,
    input  logic                      nRST,
    input  seg_t [`NUM_DIGITS-1:0]    seg_in,  // one pattern per digit
    output seg_t                      seg,     // shared segment bus
    output logic [`NUM_DIGITS-1:0]    an       // active-low digit enable
);

    localparam int ND   = `NUM_DIGITS;
    localparam int RW   = $clog2(`REFRESH_DIV);
    localparam int IW   = (ND > 1) ? $clog2(ND) : 1;

    logic [RW-1:0] ref_cnt;                 // clocks on current digit
    logic [IW-1:0] idx;                     // digit being shown

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            ref_cnt <= '0;
            idx     <= '0;
            seg     <= SEG_OFF;
            an      <= ~ND'(1);             // digit 0 selected
        end else begin
            if (ref_cnt == RW'(`REFRESH_DIV - 1)) begin
                ref_cnt <= '0;
                idx     <= (idx == IW'(ND - 1)) ? '0 : idx + IW'(1);
            end else begin
                ref_cnt <= ref_cnt + RW'(1);
            end
            seg <= seg_in[idx];
            an  <= ~(ND'(1) << idx);
        end
    end

endmodule

`default_nettype wire

/* source/keypad_calc_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_macros.svh"

module keypad_calc_top import calc_disp_pkg::*; (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [3:0]             row_in,  // keypad rows
    output logic [3:0]             col_out, // keypad columns
    output seg_t                   seg,
    output logic [`NUM_DIGITS-1:0] an
);

    nibble_t [`NUM_DIGITS-1:0] digits;      // controller to decoders
    logic    [`NUM_DIGITS-1:0] blank;
    seg_t    [`NUM_DIGITS-1:0] seg_all;     // decoders to display scanner

    key_if kif ();

    input_control u_input (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .key     (kif.scanner)
    );

    calc_controller u_ctrl (
        .clk    (clk),
        .nRST   (nRST),
        .key    (kif.controller),
        .digits (digits),
        .blank  (blank)
    );

    // one decoder per digit
    for (genvar i = 0; i < `NUM_DIGITS; i++) begin : g_digit
        seg_digit u_seg (
            .nib   (digits[i]),
            .blank (blank[i]),
            .seg   (seg_all[i])
        );
    end

    display_scan u_disp (
        .clk    (clk),
        .nRST   (nRST),
        .seg_in (seg_all),
        .seg    (seg),
        .an     (an)
    );

endmodule

`default_nettype wire

/* tests/keypad_calc_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module keypad_calc_assert (
    input logic       clk,
    input logic       nRST,
    input logic [3:0] row_in,
    input logic [3:0] col_out,
    input logic       key_rdy,
    input logic       key_rd
);

    // only one column pulled low at a time
    col_one_cold: assert property (@(posedge clk) disable iff (!nRST) $onehot(~col_out))
        else $error("col_out %b is not one-cold", col_out);

    rdy_low_in_reset: assert property (@(posedge clk) !nRST |-> !key_rdy)
        else $error("key_rdy high during reset");

    // ready drops only after a sample with every row high
    rdy_falls_released: assert property (@(posedge clk) disable iff (!nRST)
        $fell(key_rdy) |-> $past(&row_in))
        else $error("key_rdy fell while a row was low");

    rd_needs_rdy: assert property (@(posedge clk) disable iff (!nRST) key_rd |-> key_rdy)
        else $error("key_rd without key_rdy");

endmodule

`default_nettype wire

/* tests/keypad_calc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "calc_macros.svh"

module keypad_calc_tb import calc_key_pkg::*; ();

    localparam int MAX_TESTS = 16;
    localparam int GAP       = 20;                        // release cycles after each key
    localparam int ROUND     = `NUM_DIGITS * `REFRESH_DIV; // one full display refresh
    // active-low patterns for 0..F, segment a in bit 0
    localparam logic [6:0] SEG_HEX [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
        7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};

    logic                   clk, nRST;
    logic [3:0]             row_in, col_out;
    logic [6:0]             seg;
    logic [`NUM_DIGITS-1:0] an;
    key_code_u              pressed;                  // key under the finger
    logic                   pressing;

    string                  name_t [MAX_TESTS];
    string                  keys_t [MAX_TESTS];       // one char per key press
    int                     hold_t [MAX_TESTS];       // press length in cycles
    logic [`DATA_W-1:0]     exp_t  [MAX_TESTS];
    int                     n_tests = 0;
    int                     seed = 70978;
    int                     cycles = 0;
    int                     limit = 0;
    int                     n_pass = 0, n_fail = 0;
    int                     rd_count = 0;             // key_rd strobes so far
    logic                   test_bad;                 // key or display fault in this test

    keypad_calc_top dut0 (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .seg     (seg),
        .an      (an)
    );

    bind input_control keypad_calc_assert u_assert (
        .clk     (clk),
        .nRST    (nRST),
        .row_in  (row_in),
        .col_out (col_out),
        .key_rdy (rdy),
        .key_rd  (key.key_rd)
    );

    always #5 clk = ~clk;

    // row answers for the column seen this edge
    always @(posedge clk) begin
        if (pressing && !col_out[pressed.pos.col])
            row_in <= ~(4'b0001 << pressed.pos.row);
        else
            row_in <= 4'hF;
    end

    // strobe counted away from the edge that moves it
    always @(negedge clk) begin
        if (dut0.kif.key_rd)
            rd_count++;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // x is mul, n is neg, = is the equal key
    function automatic key_code_u key_of(input byte c);
        string     m = "123+456-789x=0#n";
        key_code_u k;
        k.raw = 4'hE;                                     // unknown char acts as '#'
        for (int i = 0; i < 16; i++)
            if (m[i] == c) k.raw = 4'(i);
        return k;
    endfunction

    function automatic logic [4:0] nib_of(input logic [6:0] s);
        logic [4:0] r;
        r = (s == 7'h7F) ? 5'h00 : 5'h10;                 // dark reads 0, bit 4 flags unknown
        for (int i = 0; i < 16; i++)
            if (SEG_HEX[i] == s) r = 5'(i);
        return r;
    endfunction

    // leading zero digits go dark, digit 0 always lit
    function automatic logic [`NUM_DIGITS-1:0] lead_zero_mask(input logic [`DATA_W-1:0] v);
        logic [`NUM_DIGITS-1:0] m;
        m = '0;
        for (int i = `NUM_DIGITS - 1; i > 0; i--) begin
            if (v[4*i +: 4] != 4'h0)
                break;
            m[i] = 1'b1;
        end
        return m;
    endfunction

    task automatic add_test(input string nm, input string ks, input int hold,
                            input logic [`DATA_W-1:0] ev);
        name_t[n_tests] = nm;
        keys_t[n_tests] = ks;
        hold_t[n_tests] = hold;
        exp_t[n_tests]  = ev;
        n_tests++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        nRST     <= 1'b0;
        pressing <= 1'b0;
        repeat (4) @(posedge clk);
        nRST     <= 1'b1;
    endtask

    // press, hold and release one key, expecting a single key_rd strobe
    task automatic press_key(input byte c, input int hold, input string nm);
        int first;
        first = rd_count;
        @(posedge clk);
        pressed  <= key_of(c);
        pressing <= 1'b1;
        repeat (hold) @(posedge clk);
        pressing <= 1'b0;
        repeat (GAP) @(posedge clk);
        if (rd_count - first != 1) begin
            $display("%s: key '%c' was taken %0d times instead of once",
                     nm, c, rd_count - first);
            test_bad = 1'b1;
        end
    endtask

    // samples two refresh rounds away from the clock edge
    task automatic read_display(output logic [`DATA_W-1:0] val,
                                output logic [`NUM_DIGITS-1:0] dark);
        logic [4:0]             d;
        logic [3:0]             nib [`NUM_DIGITS];
        logic [`NUM_DIGITS-1:0] seen;                     // an went low for the digit
        seen = '0;
        dark = '0;
        for (int i = 0; i < `NUM_DIGITS; i++) nib[i] = 4'h0;
        repeat (2 * ROUND) begin
            @(negedge clk);
            for (int i = 0; i < `NUM_DIGITS; i++) begin
                if (!an[i]) begin
                    d = nib_of(seg);
                    if (d[4]) begin
                        $display("digit %0d shows unknown segment pattern %h", i, seg);
                        test_bad = 1'b1;
                    end
                    nib[i]  = d[3:0];
                    dark[i] = (seg == 7'h7F);
                    seen[i] = 1'b1;
                end
            end
        end
        if (seen != '1) begin
            $display("digits %b were never selected on an", ~seen);
            test_bad = 1'b1;
        end
        val = '0;
        for (int i = 0; i < `NUM_DIGITS; i++) val[4*i +: 4] = nib[i];
    endtask

    initial begin
        logic [`DATA_W-1:0]     got;
        logic [`NUM_DIGITS-1:0] dark, exp_dark;
        string                  ks;
        int                     a, b;
        clk       = 1'b0;
        nRST      = 1'b0;
        row_in    = 4'hF;
        pressed   = '0;
        pressing  = 1'b0;
        add_test("reset_zero", "",         40, 16'h0000);
        add_test("digits_123", "123",      40, 16'h007B);
        add_test("add",        "25+17=",   40, 16'h002A);
        add_test("chain",      "5+3-2=",   40, 16'h0006);
        add_test("sub_wrap",   "3-5=",     40, 16'hFFFE);
        add_test("mul_wrap",   "300x300=", 40, 16'h5F90);
        add_test("neg",        "7n",       40, 16'hFFF9);
        add_test("neg_twice",  "7nn",      40, 16'h0007);
        add_test("mul_zero",   "7nnx0=",   40, 16'h0000);
        add_test("hash_skip",  "4#2",      40, 16'h002A);
        add_test("hold_long",  "9",       200, 16'h0009);
        for (int t = 0; t < 3; t++) begin
            a  = {$random(seed)} % 1000;
            b  = {$random(seed)} % 1000;
            ks = $sformatf("%03d+%03d=", a, b);          // three digit keys per operand
            add_test($sformatf("rand_sum_%0d", t), ks, 40, 16'(a + b));
        end
        for (int t = 0; t < n_tests; t++)
            limit += keys_t[t].len() * (hold_t[t] + GAP);
        limit += 2000;                                    // resets and display reads
        for (int t = 0; t < n_tests; t++) begin
            test_bad = 1'b0;
            apply_reset();
            ks = keys_t[t];
            for (int k = 0; k < ks.len(); k++)
                press_key(ks[k], hold_t[t], name_t[t]);
            read_display(got, dark);
            exp_dark = lead_zero_mask(exp_t[t]);
            if (got !== exp_t[t]) begin
                $display("[ERROR] %s: expected %h, actual %h", name_t[t], exp_t[t], got);
                n_fail++;
            end else if (dark !== exp_dark) begin
                $display("[ERROR] %s: expected dark digits %b, actual %b",
                         name_t[t], exp_dark, dark);
                n_fail++;
            end else if (test_bad) begin
                $display("[FAIL] %s: display is right but a key or segment fault came up",
                         name_t[t]);
                n_fail++;
            end else begin
                $display("[PASS] %s: %h", name_t[t], got);
                n_pass++;
            end
        end
        $display("%0d tests, %0d passed, %0d failed", n_tests, n_pass, n_fail);
        if (n_fail == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
source/calc_key_pkg.sv
source/calc_disp_pkg.sv
source/key_if.sv
source/input_control.sv
source/calc_controller.sv
source/seg_digit.sv
source/display_scan.sv
source/keypad_calc_top.sv
tests/keypad_calc_assert.sv
tests/keypad_calc_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the keypad calculator testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module keypad_calc_tb -Mdir obj_dir -o keypad_calc_sim > build.log 2>&1 \
    && ./obj_dir/keypad_calc_sim > sim.log 2>&1 \
    && grep -q "^No errors$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see build.log and sim.log"; exit 1; }
